//--- run_sim.sh
#!/bin/sh
# build and run the soc_periph testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_soc_periph -f soc_periph.f \
    --Mdir "$BUILD_DIR" -o sim_soc_periph
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/sim_soc_periph" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
exit 0

//--- soc_periph.f
verilog/soc_pkg.sv
verilog/bus_decode.sv
verilog/timer.sv
verilog/stdout_port.sv
verilog/char_fifo.sv
verilog/uart_tx.sv
verilog/soc_periph.sv
tb/tb_soc_periph.sv

//--- tb/tb_soc_periph.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_periph;
    import soc_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int SEED         = 91780;
    localparam int BIT_TIME     = BAUD_DIV * CLK_PERIOD;
    localparam int BUS_WAIT     = 4 * FRAME_BITS * BAUD_DIV;
    localparam int DRAIN_LIMIT  = (FIFO_DEPTH + 2) * FRAME_BITS * BAUD_DIV;
    localparam int CMP_AHEAD    = 40;
    // four tests of ten frames each, plus margin for the short ones
    localparam int WATCHDOG_CYCLES = 4 * 10 * FRAME_BITS * BAUD_DIV + 2000;

    logic            clk = 1'b0;
    logic            arst_n;
    logic            d_valid;
    logic [63:0]     d_addr;
    logic [63:0]     d_wdata;
    mem_store_type_t d_store_type;
    logic [63:0]     d_rdata;
    logic            d_ready;
    logic [7:0]      interrupt_sources;
    logic            tx;

    char_t expected_q[$];
    char_t rx_q[$];
    string cur_test;
    int    errors;
    int    errors_at_start;
    int    checks;
    int    tests_run;
    int    tests_failing;

    soc_periph soc_periph_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_equal(input string label, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERR %s (%s) expected %0h actual %0h", cur_test, label, expected, actual);
        end
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("%-14s ok", cur_test);
        end else begin
            tests_failing++;
            $display("%-14s FAILED with %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    // holds the request until the edge after ready is seen mid-cycle
    task automatic transfer(input logic [63:0] addr, input logic [63:0] wdata,
                            input mem_store_type_t st, input int max_cycles,
                            output logic [63:0] rdata, output logic done,
                            output int stalls, output time t_done);
        int n;
        @(posedge clk);
        #2;
        d_valid      = 1'b1;
        d_addr       = addr;
        d_wdata      = wdata;
        d_store_type = st;
        done   = 1'b0;
        stalls = 0;
        rdata  = '0;
        n      = 0;
        while (!done && n < max_cycles) begin
            @(negedge clk);
            if (d_ready) begin
                done  = 1'b1;
                rdata = d_rdata;
            end else begin
                stalls++;
            end
            n++;
        end
        @(posedge clk);
        t_done = $time;
        #2;
        d_valid      = 1'b0;
        d_store_type = STORE_NONE;
    endtask

    task automatic bus_read(input logic [63:0] addr, output logic [63:0] data,
                            output time t_done);
        logic done;
        int   stalls;
        transfer(addr, 64'd0, STORE_NONE, BUS_WAIT, data, done, stalls, t_done);
        if (!done) begin
            errors++;
            $display("%s: read at %h was never acknowledged", cur_test, addr);
        end
    endtask

    task automatic bus_write(input logic [63:0] addr, input logic [63:0] data,
                             input mem_store_type_t st, output int stalls);
        logic [63:0] unused;
        logic        done;
        time         t_done;
        transfer(addr, data, st, BUS_WAIT, unused, done, stalls, t_done);
        if (!done) begin
            errors++;
            $display("%s: write at %h was never acknowledged", cur_test, addr);
        end
    endtask

    // sends n random characters, junk above the low byte
    task automatic send_characters(input int n, output int stall_total);
        char_t c;
        int    stalls;
        stall_total = 0;
        for (int i = 0; i < n; i++) begin
            c = char_t'($urandom());
            bus_write(STDOUT_ADDR, {$urandom(), $urandom()} & ~64'hff | 64'(c),
                      STORE_BYTE, stalls);
            expected_q.push_back(c);
            stall_total += stalls;
        end
    endtask

    // wait for the line to catch up, then compare in write order
    task automatic drain_serial();
        int waited;
        waited = 0;
        while (rx_q.size() < expected_q.size() && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        check_equal("frame_count", expected_q.size(), rx_q.size());
        for (int i = 0; i < rx_q.size() && i < expected_q.size(); i++) begin
            check_equal("character", expected_q[i], rx_q[i]);
        end
        expected_q.delete();
        rx_q.delete();
    endtask

    // samples half a clock past mid-bit so tx is settled
    always begin : serial_monitor
        char_t data;
        wait (arst_n === 1'b1);
        @(negedge tx);
        #(BIT_TIME / 2 + CLK_PERIOD / 2);
        check_equal("start_bit", 1'b0, tx);
        for (int i = 0; i < 8; i++) begin
            #(BIT_TIME);
            data[i] = tx;
        end
        #(BIT_TIME);
        check_equal("stop_bit", 1'b1, tx);
        rx_q.push_back(data);
    end

    a_ready_needs_valid: assert property (
        @(posedge clk) disable iff (!arst_n)
        d_ready |-> d_valid
    ) else begin
        errors++;
        $display("d_ready was high without a request");
    end

    a_unused_irqs_low: assert property (
        @(posedge clk) disable iff (!arst_n)
        interrupt_sources[6:0] == 7'd0
    ) else begin
        errors++;
        $display("an unused interrupt line went high");
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin : main
        logic [63:0] v1;
        logic [63:0] v2;
        logic [63:0] cmp;
        logic [63:0] ctr;
        logic        done;
        time         t1;
        time         t2;
        int          stalls;
        void'($urandom(SEED));
        arst_n       = 1'b0;
        d_valid      = 1'b0;
        d_addr       = '0;
        d_wdata      = '0;
        d_store_type = STORE_NONE;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;

        cur_test = "reset_state";
        errors_at_start = errors;
        @(negedge clk);
        check_equal("tx", 1'b1, tx);
        check_equal("irq", 8'd0, interrupt_sources);
        check_equal("ready", 1'b0, d_ready);
        bus_read(TIMER_MTIMECMP_ADDR, v1, t1);
        check_equal("mtimecmp", '1, v1);
        end_test();

        cur_test = "counter_rate";
        errors_at_start = errors;
        bus_read(TIMER_MTIME_ADDR, v1, t1);
        repeat ($urandom_range(5, 40)) @(posedge clk);
        bus_read(TIMER_MTIME_ADDR, v2, t2);
        check_equal("delta", (t2 - t1) / CLK_PERIOD, v2 - v1);
        end_test();

        cur_test = "compare_irq";
        errors_at_start = errors;
        bus_read(TIMER_MTIME_ADDR, v1, t1);
        cmp = v1 + CMP_AHEAD;
        bus_write(TIMER_MTIMECMP_ADDR, cmp, STORE_DOUBLE, stalls);
        bus_read(TIMER_MTIMECMP_ADDR, v2, t2);
        check_equal("readback", cmp, v2);
        // irq reflects the counter value before the last edge
        for (int i = 0; i < CMP_AHEAD + 8; i++) begin
            @(negedge clk);
            ctr = v1 + 1 + ($time - t1) / CLK_PERIOD;
            check_equal("irq_bit", (ctr - 1) >= cmp, interrupt_sources[TIMER_IRQ_BIT]);
        end
        bus_write(TIMER_MTIMECMP_ADDR, '1, STORE_DOUBLE, stalls);
        @(posedge clk);
        @(negedge clk);
        check_equal("irq_cleared", 1'b0, interrupt_sources[TIMER_IRQ_BIT]);
        end_test();

        cur_test = "serial_order";
        errors_at_start = errors;
        send_characters(10, stalls);
        drain_serial();
        end_test();

        cur_test = "back_pressure";
        errors_at_start = errors;
        send_characters(2 * FIFO_DEPTH, stalls);
        check_equal("stalled", 1'b1, stalls > 0);
        drain_serial();
        end_test();

        cur_test = "unanswered";
        errors_at_start = errors;
        transfer(PERIPHERAL_BASE + 64'h100, 64'd0, STORE_WORD, 20, v1, done, stalls, t1);
        check_equal("unmapped_ready", 1'b0, done);
        transfer(STDOUT_ADDR, 64'd0, STORE_NONE, 20, v1, done, stalls, t1);
        check_equal("stdout_read_ready", 1'b0, done);
        end_test();

        $display("tests %0d, failing %0d, checks %0d, errors %0d",
                 tests_run, tests_failing, checks, errors);
        if (errors == 0 && tests_failing == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
    input  logic        timer_taken,
    input  logic        stdout_taken,
    input  logic [63:0] timer_rdata,
    output logic [63:0] d_rdata,
    output logic        d_ready
);

    // read data from whichever peripheral claims the address
    // stdout is write only so it never returns data
    always_comb begin
        d_rdata = '0;
        if (timer_taken) begin
            d_rdata = timer_rdata;
        end
    end

    // ready in the same cycle as the hit
    // an address nobody claims is never acknowledged
    assign d_ready = timer_taken | stdout_taken;

    // the peripheral address windows must not overlap
    always_comb begin
        assert final (!(timer_taken && stdout_taken))
        else $error("bus_decode: timer and stdout both claim the access");
    end

endmodule

`default_nettype wire

//--- verilog/char_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module char_fifo (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           push,
    input  soc_pkg::char_t push_data,
    input  logic           pop,
    output soc_pkg::char_t head,
    output logic           full,
    output logic           empty
);
    import soc_pkg::*;

    char_t              mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head  = mem[rd_ptr];
    assign full  = count == (FIFO_AW + 1)'(FIFO_DEPTH);
    assign empty = count == '0;

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        push |-> !full
    ) else $error("char_fifo: overflow");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        pop |-> !empty
    ) else $error("char_fifo: underflow");

endmodule

`default_nettype wire

//--- verilog/soc_periph.sv
`timescale 1ns/1ps
`default_nettype none

module soc_periph (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     d_valid,
    input  logic [63:0]              d_addr,
    input  logic [63:0]              d_wdata,
    input  soc_pkg::mem_store_type_t d_store_type,
    output logic [63:0]              d_rdata,
    output logic                     d_ready,
    output logic [7:0]               interrupt_sources,
    output logic                     tx
);
    import soc_pkg::*;

    bus_req_t    req;
    logic        timer_taken;
    logic        stdout_taken;
    logic [63:0] timer_rdata;
    logic        timer_irq;
    logic        push;
    char_t       push_data;
    logic        pop;
    char_t       head;
    logic        full;
    logic        empty;

    assign req = '{valid: d_valid, addr: d_addr, wdata: d_wdata, store_type: d_store_type};

    // only the machine timer raises an interrupt for now
    always_comb begin
        interrupt_sources = '0;
        interrupt_sources[TIMER_IRQ_BIT] = timer_irq;
    end

    bus_decode bus_decode_i (
        .timer_taken  (timer_taken),
        .stdout_taken (stdout_taken),
        .timer_rdata  (timer_rdata),
        .d_rdata      (d_rdata),
        .d_ready      (d_ready)
    );

    timer timer_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .taken  (timer_taken),
        .rdata  (timer_rdata),
        .irq    (timer_irq)
    );

    stdout_port stdout_port_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .full      (full),
        .taken     (stdout_taken),
        .push      (push),
        .push_data (push_data)
    );

    char_fifo char_fifo_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (head),
        .full      (full),
        .empty     (empty)
    );

    uart_tx uart_tx_i (
        .clk    (clk),
        .arst_n (arst_n),
        .empty  (empty),
        .head   (head),
        .pop    (pop),
        .tx     (tx)
    );

endmodule

`default_nettype wire

//--- verilog/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // store width on the data bus, none marks a read
    typedef enum logic [2:0] {
        STORE_NONE   = 3'd0,
        STORE_BYTE   = 3'd1,
        STORE_HALF   = 3'd2,
        STORE_WORD   = 3'd3,
        STORE_DOUBLE = 3'd4
    } mem_store_type_t;

    // one data bus request as driven by the core
    typedef struct packed {
        logic            valid;
        logic [63:0]     addr;
        logic [63:0]     wdata;
        mem_store_type_t store_type;
    } bus_req_t;

    typedef logic [7:0] char_t;

    // address map
    localparam logic [63:0] PERIPHERAL_BASE     = 64'h0000_0000_8000_0000;
    localparam logic [63:0] TIMER_MTIME_ADDR    = PERIPHERAL_BASE;
    localparam logic [63:0] TIMER_MTIMECMP_ADDR = TIMER_MTIME_ADDR + 64'd8;
    localparam logic [63:0] STDOUT_ADDR         = PERIPHERAL_BASE + 64'd64;

    // character buffer
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // serial line, 8N1
    localparam int BAUD_DIV   = 8;
    localparam int BAUD_W     = $clog2(BAUD_DIV);
    localparam int FRAME_BITS = 10;
    localparam int BIT_W      = $clog2(FRAME_BITS);

    // slot of the machine timer in the interrupt vector
    localparam int TIMER_IRQ_BIT = 7;

endpackage

`default_nettype wire

//--- verilog/stdout_port.sv
`timescale 1ns/1ps
`default_nettype none

module stdout_port (
    input  logic              clk,
    input  logic              arst_n,
    input  soc_pkg::bus_req_t req,
    input  logic              full,
    output logic              taken,
    output logic              push,
    output soc_pkg::char_t    push_data
);
    import soc_pkg::*;

    logic hit;

    // only stores count, reads of this address stay unanswered
    assign hit = req.valid && (req.addr == STDOUT_ADDR) && (req.store_type != STORE_NONE);

    // hold the core off while the buffer has no room
    assign taken = hit && !full;

    // character enters the buffer on the completing edge
    assign push      = taken;
    assign push_data = req.wdata[7:0];

    // a held-off store stays on the bus until there is room
    a_hold_while_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        (hit && full) |=> hit
    ) else $error("stdout_port: held-off store dropped before it was taken");

endmodule

`default_nettype wire

//--- verilog/timer.sv
`timescale 1ns/1ps
`default_nettype none

module timer (
    input  logic              clk,
    input  logic              arst_n,
    input  soc_pkg::bus_req_t req,
    output logic              taken,
    output logic [63:0]       rdata,
    output logic              irq
);
    import soc_pkg::*;

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        hit_mtime;
    logic        hit_cmp;
    logic        is_write;
    logic [63:0] wmask;

    // bytes touched by a store of the given width
    function automatic logic [63:0] store_mask(mem_store_type_t st);
        case (st)
            STORE_BYTE:   store_mask = 64'h0000_0000_0000_00ff;
            STORE_HALF:   store_mask = 64'h0000_0000_0000_ffff;
            STORE_WORD:   store_mask = 64'h0000_0000_ffff_ffff;
            STORE_DOUBLE: store_mask = 64'hffff_ffff_ffff_ffff;
            default:      store_mask = '0;
        endcase
    endfunction

    assign hit_mtime = req.valid && (req.addr == TIMER_MTIME_ADDR);
    assign hit_cmp   = req.valid && (req.addr == TIMER_MTIMECMP_ADDR);
    assign is_write  = req.store_type != STORE_NONE;
    assign wmask     = store_mask(req.store_type);

    // writes to mtime are dropped but still acknowledged
    assign taken = hit_mtime | hit_cmp;
    assign rdata = hit_cmp ? mtimecmp : mtime;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // compare starts at all ones so nothing fires out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtimecmp <= '1;
        end else if (hit_cmp && is_write) begin
            mtimecmp <= (mtimecmp & ~wmask) | (req.wdata & wmask);
        end
    end

    // registered compare, one cycle behind the counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= mtime >= mtimecmp;
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           empty,
    input  soc_pkg::char_t head,
    output logic           pop,
    output logic           tx
);
    import soc_pkg::*;

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

    tx_state_t              state;
    logic [FRAME_BITS-1:0]  shift;
    logic [BAUD_W-1:0]      baud_cnt;
    logic [BIT_W-1:0]       bit_cnt;
    logic                   bit_end;
    logic                   last_bit;

    assign bit_end  = (state == TX_SEND) && (baud_cnt == BAUD_W'(BAUD_DIV - 1));
    assign last_bit = bit_cnt == BIT_W'(FRAME_BITS - 1);

    // take a new character when idle or right as the stop bit ends,
    // so frames can run back to back
    assign pop = !empty && ((state == TX_IDLE) || (bit_end && last_bit));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= TX_IDLE;
            shift    <= '1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (pop) begin
            // stop, data lsb first, start
            state    <= TX_SEND;
            shift    <= {1'b1, head, 1'b0};
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (bit_end) begin
            baud_cnt <= '0;
            shift    <= {1'b1, shift[FRAME_BITS-1:1]};
            if (last_bit) begin
                state   <= TX_IDLE;
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else if (state == TX_SEND) begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // line idles high because the shifter fills with ones
    assign tx = shift[0];

    a_idle_high: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state == TX_IDLE) |-> tx
    ) else $error("uart_tx: line low while idle");

endmodule

`default_nettype wire
